// ==== bench/id_checker.sv ====
`timescale 1ns/1ps

module id_checker (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_req,
    input  logic                    in_ack,
    input  logic                    out_req,
    input  logic                    out_ack,
    input  loong_id_pkg::word_t     out_pc,
    input  loong_id_pkg::word_t     out_inst,
    input  logic                    out_exc_valid,
    input  loong_id_pkg::exc_code_t out_exc_code,
    input  logic                    out_reg_write_en,
    input  loong_id_pkg::reg_addr_t out_reg_write_addr,
    input  logic                    out_reg1_read_en,
    input  loong_id_pkg::reg_addr_t out_reg1_read_addr,
    input  logic                    out_reg2_read_en,
    input  loong_id_pkg::reg_addr_t out_reg2_read_addr,
    input  loong_id_pkg::aluop_t    out_aluop,
    input  loong_id_pkg::alusel_t   out_alusel,
    input  loong_id_pkg::word_t     out_imm,
    input  logic                    out_csr_read_en,
    input  logic                    out_csr_write_en,
    input  loong_id_pkg::csr_addr_t out_csr_addr,
    output int                      checked,
    output int                      errors
);
    localparam int NCOL = 17;
    localparam int MAXV = 64;

    logic [31:0] gold [0:MAXV*NCOL-1];
    logic [31:0] obs [0:NCOL-1];  // out_ fields in golden column order
    logic [31:0] held [0:NCOL-1];
    string       names [0:NCOL-1] = '{"out_pc", "out_inst", "plv", "out_exc_valid",
        "out_exc_code", "out_reg_write_en", "out_reg_write_addr", "out_reg1_read_en",
        "out_reg1_read_addr", "out_reg2_read_en", "out_reg2_read_addr", "out_aluop",
        "out_alusel", "out_imm", "out_csr_read_en", "out_csr_write_en", "out_csr_addr"};
    int          nv = 0;
    int          n_checked = 0;
    int          n_errors = 0;
    logic        in_reset = 1'b1;
    logic        holding = 1'b0;
    logic        last_in_req = 1'b0;
    logic        last_in_ack = 1'b0;
    logic        last_out_req = 1'b0;
    logic        last_out_ack = 1'b0;

    assign checked = n_checked;
    assign errors  = n_errors;

    always_comb begin
        obs[0]  = out_pc;
        obs[1]  = out_inst;
        obs[2]  = 32'd0;          // plv is stimulus only
        obs[3]  = 32'(out_exc_valid);
        obs[4]  = 32'(out_exc_code);
        obs[5]  = 32'(out_reg_write_en);
        obs[6]  = 32'(out_reg_write_addr);
        obs[7]  = 32'(out_reg1_read_en);
        obs[8]  = 32'(out_reg1_read_addr);
        obs[9]  = 32'(out_reg2_read_en);
        obs[10] = 32'(out_reg2_read_addr);
        obs[11] = 32'(out_aluop);
        obs[12] = 32'(out_alusel);
        obs[13] = out_imm;
        obs[14] = 32'(out_csr_read_en);
        obs[15] = 32'(out_csr_write_en);
        obs[16] = 32'(out_csr_addr);
    end

    initial begin
        int i;
        for (i = 0; i < MAXV*NCOL; i++) gold[i] = 32'hffff0000 | i;
        $readmemh("bench/id_golden.mem", gold);
        while (nv < MAXV && gold[nv*NCOL+2] < 4) nv++;
    end

    task automatic handshake_error(input string what);
        $display("handshake error at t=%0d ns: %s", $time, what);
        n_errors++;
    endtask

    task automatic compare_record();
        int c;
        int base;
        int mism;
        base = n_checked * NCOL;
        mism = 0;
        if (n_checked >= nv) begin
            handshake_error("out_req pulse after the last vector");
        end else begin
            for (c = 0; c < NCOL; c++) begin
                if (c != 2 && obs[c] !== gold[base+c]) begin
                    $display("[FAIL] t=%0d ns vector %0d %s: expected %h, got %h",
                             $time, n_checked, names[c], gold[base+c], obs[c]);
                    mism++;
                end
            end
            if (mism == 0)
                $display("vector %0d ok, inst %h", n_checked, gold[base+1]);
            else
                $display("vector %0d failed, %0d fields wrong", n_checked, mism);
            n_errors += mism;
            n_checked++;
        end
        for (c = 0; c < NCOL; c++) held[c] = obs[c];
    endtask

    task automatic compare_held();
        int c;
        for (c = 0; c < NCOL; c++) begin
            if (obs[c] !== held[c]) begin
                $display("[FAIL] t=%0d ns %s changed while the record was held",
                         $time, names[c]);
                n_errors++;
                held[c] = obs[c];
            end
        end
    endtask

    always @(posedge clk) begin
        if (!arst_n) begin
            in_reset = 1'b1;
        end else begin
            if (in_reset && (in_ack || out_req))
                handshake_error("in_ack or out_req high when reset ended");
            in_reset = 1'b0;
            if (in_ack && !last_in_ack && !last_in_req)
                handshake_error("in_ack rose while in_req was low");
            if (!in_ack && last_in_ack && last_in_req)
                handshake_error("in_ack fell while in_req was still high");
            if (!out_req && last_out_req && !last_out_ack)
                handshake_error("out_req fell before out_ack rose");
            if (out_req && !last_out_req) begin
                if (last_in_req || in_ack)
                    handshake_error("out_req rose before the input handshake closed");
                compare_record();
                holding = 1'b1;
            end else if (holding) begin
                compare_held();
                holding = out_req || out_ack; // held until out_ack drops
            end
        end
        last_in_req  = in_req;
        last_in_ack  = in_ack;
        last_out_req = out_req;
        last_out_ack = out_ack;
    end

endmodule

// ==== bench/id_golden.mem ====
// pc inst plv | exc_valid exc_code wr_en wr_addr r1_en r1_addr r2_en r2_addr
// aluop alusel imm csr_rd_en csr_wr_en csr_addr (out_pc and out_inst echo pc and inst)
1c000000 20004064 0 0 00 1 04 1 03 0 00 12 3 00000040 1 0 0060
1c000004 20fffcc5 0 0 00 1 05 1 06 0 00 12 3 fffffffc 1 0 0060
1c000008 21800107 0 0 00 1 07 1 08 1 07 13 3 ffff8000 1 0 0060
1c00000c 21048c41 0 0 00 1 01 1 02 1 01 13 3 0000048c 1 0 0060
1c000010 0400140a 0 0 00 1 0a 0 00 0 00 20 4 00000000 1 0 0005
1c000014 0400442c 0 0 00 1 0c 1 0c 0 00 21 4 00000000 1 1 0011
1c000018 0406952d 0 0 00 1 0d 1 0d 1 09 22 4 00000000 1 1 01a5
1c00001c 0400140a 3 1 0e 0 0a 0 00 0 00 20 4 00000000 1 0 0005
1c000020 0400442c 3 1 0e 0 0c 1 0c 0 00 21 4 00000000 1 0 0011
1c000024 0406952d 3 1 0e 0 0d 1 0d 1 09 22 4 00000000 1 0 01a5
1c000028 0400442c 1 1 0e 0 0c 1 0c 0 00 21 4 00000000 1 0 0011
1c00002c 00100c41 0 0 00 1 01 1 02 1 03 01 1 00000000 0 0 0000
1c000030 001177df 0 0 00 1 1f 1 1e 1 1d 02 1 00000000 0 0 0000
1c000034 001218a4 0 0 00 1 04 1 05 1 06 03 1 00000000 0 0 0000
1c000038 0014a507 0 0 00 1 07 1 08 1 09 04 2 00000000 0 0 0000
1c00003c 0015316a 0 0 00 1 0a 1 0b 1 0c 05 2 00000000 0 0 0000
1c000040 00158820 0 0 00 1 00 1 01 1 02 06 2 00000000 0 0 0000
1c000044 02a00083 0 0 00 1 03 1 04 0 00 01 1 fffff800 0 0 0000
1c000048 0281fc05 0 0 00 1 05 1 00 0 00 01 1 0000007f 0 0 0000
1c00004c 037ffce6 0 0 00 1 06 1 07 0 00 04 2 00000fff 0 0 0000
1c000050 03a00528 0 0 00 1 08 1 09 0 00 05 2 00000801 0 0 0000
1c000054 28bff06a 0 0 00 1 0a 1 03 0 00 10 3 fffffffc 0 0 0000
1c000058 2980418b 0 0 00 0 00 1 0c 1 0b 11 3 00000010 0 0 0000
1c00005c 00000000 0 1 0d 0 00 0 00 0 00 00 0 00000000 0 0 0000
1c000060 ffffffff 3 1 0d 0 00 0 00 0 00 00 0 00000000 0 0 0000
1c000064 00108c41 0 1 0d 0 00 0 00 0 00 00 0 00000000 0 0 0000

// ==== bench/tb_id_stage.sv ====
`timescale 1ns/1ps

module tb_id_stage;
    localparam int NCOL = 17; // golden columns per vector
    localparam int MAXV = 64;

    logic                    clk;
    logic                    arst_n;
    logic                    in_req;
    logic                    in_ack;
    loong_id_pkg::word_t     in_pc;
    loong_id_pkg::word_t     in_inst;
    loong_id_pkg::plv_t      plv;
    logic                    out_req;
    logic                    out_ack;
    loong_id_pkg::word_t     out_pc;
    loong_id_pkg::word_t     out_inst;
    logic                    out_exc_valid;
    loong_id_pkg::exc_code_t out_exc_code;
    logic                    out_reg_write_en;
    loong_id_pkg::reg_addr_t out_reg_write_addr;
    logic                    out_reg1_read_en;
    loong_id_pkg::reg_addr_t out_reg1_read_addr;
    logic                    out_reg2_read_en;
    loong_id_pkg::reg_addr_t out_reg2_read_addr;
    loong_id_pkg::aluop_t    out_aluop;
    loong_id_pkg::alusel_t   out_alusel;
    loong_id_pkg::word_t     out_imm;
    logic                    out_csr_read_en;
    logic                    out_csr_write_en;
    loong_id_pkg::csr_addr_t out_csr_addr;
    int                      checked;
    int                      errors;
    int                      nv;
    logic [31:0]             lcg;
    logic [31:0]             gold [0:MAXV*NCOL-1];
    int                      req_gap [0:MAXV-1];
    int                      hold_gap [0:MAXV-1];
    int                      ack_gap [0:MAXV-1];
    int                      rel_gap [0:MAXV-1];

    id_stage uut (.*);
    id_checker chk (.*);

    function automatic int pick_delay();
        lcg = lcg * 32'd1664525 + 32'd1013904223;
        return int'(lcg[23:8]) % 6; // 0..5 cycles
    endfunction

    task automatic send_all();
        int v;
        for (v = 0; v < nv; v++) begin
            repeat (req_gap[v]) @(negedge clk);
            in_pc   = gold[v*NCOL];
            in_inst = gold[v*NCOL+1];
            plv     = gold[v*NCOL+2][1:0];
            in_req  = 1'b1;
            while (!in_ack) @(negedge clk);
            repeat (hold_gap[v]) @(negedge clk);
            in_req = 1'b0;
            while (in_ack) @(negedge clk);
        end
    endtask

    task automatic receive_all();
        int v;
        for (v = 0; v < nv; v++) begin
            while (!out_req) @(negedge clk);
            repeat (ack_gap[v]) @(negedge clk); // back-pressure
            out_ack = 1'b1;
            while (out_req) @(negedge clk);
            repeat (rel_gap[v]) @(negedge clk);
            out_ack = 1'b0;
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    initial begin
        int i;
        arst_n  = 1'b0;
        in_req  = 1'b0;
        in_pc   = '0;
        in_inst = '0;
        plv     = '0;
        out_ack = 1'b0;
        lcg     = 32'd95004;
        for (i = 0; i < MAXV*NCOL; i++) gold[i] = 32'hffff0000 | i; // plv column stays > 3
        $readmemh("bench/id_golden.mem", gold);
        nv = 0;
        while (nv < MAXV && gold[nv*NCOL+2] < 4) nv++;
        for (i = 0; i < MAXV; i++) begin
            req_gap[i]  = pick_delay();
            hold_gap[i] = pick_delay();
            ack_gap[i]  = pick_delay();
            rel_gap[i]  = pick_delay();
        end
        repeat (8) @(negedge clk);
        arst_n = 1'b1;
        fork
            send_all();
            receive_all();
        join
        repeat (4) @(negedge clk);
        $display("done: %0d vectors, %0d checked, %0d errors", nv, checked, errors);
        if (nv > 0 && checked == nv && errors == 0) begin
            $display(">>> PASS");
        end else begin
            $display(">>> FAIL");
        end
        $finish;
    end

    initial begin
        int limit;
        #1;
        limit = nv * 30 + 200;
        repeat (limit) @(posedge clk);
        $display("timeout: run did not finish within %0d cycles, %0d of %0d vectors checked",
                 limit, checked, nv);
        $display(">>> FAIL");
        $finish;
    end

endmodule

// ==== common/decode_if.sv ====
`timescale 1ns/1ps

interface decode_if;
    logic                    inst_valid;
    logic                    is_privilege;
    logic                    reg_write_en;
    loong_id_pkg::reg_addr_t reg_write_addr;
    logic                    reg1_read_en;
    loong_id_pkg::reg_addr_t reg1_read_addr;
    logic                    reg2_read_en;
    loong_id_pkg::reg_addr_t reg2_read_addr;
    loong_id_pkg::aluop_t    aluop;
    loong_id_pkg::alusel_t   alusel;
    loong_id_pkg::word_t     imm;
    logic                    csr_read_en;
    logic                    csr_write_en;
    loong_id_pkg::csr_addr_t csr_addr;

    modport producer (
        output inst_valid, is_privilege, reg_write_en, reg_write_addr,
               reg1_read_en, reg1_read_addr, reg2_read_en, reg2_read_addr,
               aluop, alusel, imm, csr_read_en, csr_write_en, csr_addr
    );

    modport consumer (
        input  inst_valid, is_privilege, reg_write_en, reg_write_addr,
               reg1_read_en, reg1_read_addr, reg2_read_en, reg2_read_addr,
               aluop, alusel, imm, csr_read_en, csr_write_en, csr_addr
    );
endinterface

// ==== common/loong_id_pkg.sv ====
package loong_id_pkg;

    typedef logic [31:0] word_t;
    typedef logic [4:0]  reg_addr_t;
    typedef logic [13:0] csr_addr_t;
    typedef logic [7:0]  aluop_t;
    typedef logic [2:0]  alusel_t;
    typedef logic [6:0]  exc_code_t;
    typedef logic [1:0]  plv_t;

    localparam aluop_t ALU_NOP     = 8'h00;
    localparam aluop_t ALU_ADD     = 8'h01;
    localparam aluop_t ALU_SUB     = 8'h02;
    localparam aluop_t ALU_SLT     = 8'h03;
    localparam aluop_t ALU_AND     = 8'h04;
    localparam aluop_t ALU_OR      = 8'h05;
    localparam aluop_t ALU_XOR     = 8'h06;
    localparam aluop_t ALU_LD_W    = 8'h10;
    localparam aluop_t ALU_ST_W    = 8'h11;
    localparam aluop_t ALU_LL_W    = 8'h12;
    localparam aluop_t ALU_SC_W    = 8'h13;
    localparam aluop_t ALU_CSRRD   = 8'h20;
    localparam aluop_t ALU_CSRWR   = 8'h21;
    localparam aluop_t ALU_CSRXCHG = 8'h22;

    localparam alusel_t SEL_NOP   = 3'd0;
    localparam alusel_t SEL_ARITH = 3'd1;
    localparam alusel_t SEL_LOGIC = 3'd2;
    localparam alusel_t SEL_MEM   = 3'd3; // loads, stores, ll/sc
    localparam alusel_t SEL_CSR   = 3'd4;

    localparam exc_code_t EXC_NONE = 7'h00;
    localparam exc_code_t EXC_INE  = 7'h0D;
    localparam exc_code_t EXC_IPE  = 7'h0E;

    // 2ri14, bits 31..24
    localparam logic [7:0] OPC_LL_W = 8'h20;
    localparam logic [7:0] OPC_SC_W = 8'h21;
    localparam logic [7:0] OPC_CSR  = 8'h04;

    localparam reg_addr_t CSR_RJ_RD = 5'd0; // csrrd
    localparam reg_addr_t CSR_RJ_WR = 5'd1; // csrwr, others xchg

    // 3r, bits 31..15
    localparam logic [16:0] OPC_ADD_W = 17'h00020;
    localparam logic [16:0] OPC_SUB_W = 17'h00022;
    localparam logic [16:0] OPC_SLT   = 17'h00024;
    localparam logic [16:0] OPC_AND   = 17'h00029;
    localparam logic [16:0] OPC_OR    = 17'h0002A;
    localparam logic [16:0] OPC_XOR   = 17'h0002B;

    // 2ri12, bits 31..22
    localparam logic [9:0] OPC_ADDI_W = 10'h00A;
    localparam logic [9:0] OPC_ANDI   = 10'h00D;
    localparam logic [9:0] OPC_ORI    = 10'h00E;
    localparam logic [9:0] OPC_LD_W   = 10'h0A2;
    localparam logic [9:0] OPC_ST_W   = 10'h0A6;

    localparam csr_addr_t CSR_LLBCTL = 14'h060;

    typedef enum logic [1:0] {
        ST_IDLE,
        ST_IN_ACK,
        ST_OUT_REQ,
        ST_OUT_DONE
    } id_state_e;

endpackage

// ==== hw/decoder/id_2ri12.sv ====
`timescale 1ns/1ps

module id_2ri12 (
    input  loong_id_pkg::word_t inst,
    decode_if.producer          dec
);
    logic                  hit;
    logic                  zext;  // ui12 for logic ops
    logic                  store;
    loong_id_pkg::aluop_t  aluop;
    loong_id_pkg::alusel_t alusel;

    always_comb begin
        hit    = 1'b1;
        zext   = 1'b0;
        store  = 1'b0;
        aluop  = loong_id_pkg::ALU_NOP;
        alusel = loong_id_pkg::SEL_NOP;
        case (inst[31:22])
            loong_id_pkg::OPC_ADDI_W: begin
                aluop  = loong_id_pkg::ALU_ADD;
                alusel = loong_id_pkg::SEL_ARITH;
            end
            loong_id_pkg::OPC_ANDI: begin
                aluop  = loong_id_pkg::ALU_AND;
                alusel = loong_id_pkg::SEL_LOGIC;
                zext   = 1'b1;
            end
            loong_id_pkg::OPC_ORI: begin
                aluop  = loong_id_pkg::ALU_OR;
                alusel = loong_id_pkg::SEL_LOGIC;
                zext   = 1'b1;
            end
            loong_id_pkg::OPC_LD_W: begin
                aluop  = loong_id_pkg::ALU_LD_W;
                alusel = loong_id_pkg::SEL_MEM;
            end
            loong_id_pkg::OPC_ST_W: begin
                aluop  = loong_id_pkg::ALU_ST_W;
                alusel = loong_id_pkg::SEL_MEM;
                store  = 1'b1;
            end
            default: hit = 1'b0;
        endcase
    end

    assign dec.inst_valid     = hit;
    assign dec.is_privilege   = 1'b0;
    assign dec.reg_write_en   = hit && !store;
    assign dec.reg_write_addr = (hit && !store) ? inst[4:0] : '0;
    assign dec.reg1_read_en   = hit;
    assign dec.reg1_read_addr = hit ? inst[9:5] : '0;
    assign dec.reg2_read_en   = store;
    assign dec.reg2_read_addr = store ? inst[4:0] : '0; // store data in rd
    assign dec.aluop          = aluop;
    assign dec.alusel         = alusel;
    assign dec.imm            = !hit ? '0 :
                                zext ? {20'b0, inst[21:10]} : {{20{inst[21]}}, inst[21:10]};
    assign dec.csr_read_en    = 1'b0;
    assign dec.csr_write_en   = 1'b0;
    assign dec.csr_addr       = '0;

    // the merge in id_decoder relies on an all-zero record when unclaimed
    always_comb begin
        assert final (dec.inst_valid || !(dec.reg_write_en || dec.reg1_read_en
                      || dec.reg2_read_en || (|dec.imm) || (|dec.aluop) || (|dec.alusel)))
            else $error("unclaimed word leaves a nonzero record");
    end

endmodule

// ==== hw/decoder/id_2ri14.sv ====
`timescale 1ns/1ps

module id_2ri14 (
    input  loong_id_pkg::word_t inst,
    decode_if.producer          dec
);
    logic [7:0]              opcode;
    loong_id_pkg::reg_addr_t rj;
    loong_id_pkg::reg_addr_t rd;
    logic [13:0]             field14;
    loong_id_pkg::word_t     offset;

    assign opcode  = inst[31:24];
    assign rj      = inst[9:5];
    assign rd      = inst[4:0];
    assign field14 = inst[23:10];                       // si14 or csr number
    assign offset  = {{16{field14[13]}}, field14, 2'b00}; // si14 << 2

    always_comb begin
        dec.inst_valid     = 1'b0;
        dec.is_privilege   = 1'b0;
        dec.reg_write_en   = 1'b0;
        dec.reg_write_addr = '0;
        dec.reg1_read_en   = 1'b0;
        dec.reg1_read_addr = '0;
        dec.reg2_read_en   = 1'b0;
        dec.reg2_read_addr = '0;
        dec.aluop          = loong_id_pkg::ALU_NOP;
        dec.alusel         = loong_id_pkg::SEL_NOP;
        dec.imm            = '0;
        dec.csr_read_en    = 1'b0;
        dec.csr_write_en   = 1'b0;
        dec.csr_addr       = '0;
        case (opcode)
            loong_id_pkg::OPC_LL_W, loong_id_pkg::OPC_SC_W: begin
                dec.inst_valid     = 1'b1;
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
                dec.reg1_read_en   = 1'b1;
                dec.reg1_read_addr = rj;           // base
                dec.alusel         = loong_id_pkg::SEL_MEM;
                dec.imm            = offset;
                dec.csr_read_en    = 1'b1;
                dec.csr_addr       = loong_id_pkg::CSR_LLBCTL;
                dec.aluop          = loong_id_pkg::ALU_LL_W;
                if (opcode == loong_id_pkg::OPC_SC_W) begin
                    dec.aluop          = loong_id_pkg::ALU_SC_W;
                    dec.reg2_read_en   = 1'b1;
                    dec.reg2_read_addr = rd;       // store data
                end
            end
            loong_id_pkg::OPC_CSR: begin
                dec.inst_valid     = 1'b1;
                dec.is_privilege   = 1'b1;
                dec.reg_write_en   = 1'b1;
                dec.reg_write_addr = rd;
                dec.alusel         = loong_id_pkg::SEL_CSR;
                dec.csr_read_en    = 1'b1;
                dec.csr_addr       = field14;
                case (rj)
                    loong_id_pkg::CSR_RJ_RD: dec.aluop = loong_id_pkg::ALU_CSRRD;
                    loong_id_pkg::CSR_RJ_WR: begin
                        dec.aluop          = loong_id_pkg::ALU_CSRWR;
                        dec.reg1_read_en   = 1'b1;
                        dec.reg1_read_addr = rd;
                        dec.csr_write_en   = 1'b1;
                    end
                    default: begin
                        dec.aluop          = loong_id_pkg::ALU_CSRXCHG;
                        dec.reg1_read_en   = 1'b1;
                        dec.reg1_read_addr = rd;
                        dec.reg2_read_en   = 1'b1;
                        dec.reg2_read_addr = rj;   // write mask
                        dec.csr_write_en   = 1'b1;
                    end
                endcase
            end
            default: ;
        endcase
    end

    always_comb begin
        assert final (!dec.csr_write_en || dec.csr_read_en)
            else $error("csr write without csr read");
    end

endmodule

// ==== hw/decoder/id_3r.sv ====
`timescale 1ns/1ps

module id_3r (
    input  loong_id_pkg::word_t inst,
    decode_if.producer          dec
);
    logic                  hit;
    loong_id_pkg::aluop_t  aluop;
    loong_id_pkg::alusel_t alusel;

    always_comb begin
        hit    = 1'b1;
        aluop  = loong_id_pkg::ALU_NOP;
        alusel = loong_id_pkg::SEL_NOP;
        case (inst[31:15])
            loong_id_pkg::OPC_ADD_W: begin
                aluop  = loong_id_pkg::ALU_ADD;
                alusel = loong_id_pkg::SEL_ARITH;
            end
            loong_id_pkg::OPC_SUB_W: begin
                aluop  = loong_id_pkg::ALU_SUB;
                alusel = loong_id_pkg::SEL_ARITH;
            end
            loong_id_pkg::OPC_SLT: begin
                aluop  = loong_id_pkg::ALU_SLT;
                alusel = loong_id_pkg::SEL_ARITH;
            end
            loong_id_pkg::OPC_AND: begin
                aluop  = loong_id_pkg::ALU_AND;
                alusel = loong_id_pkg::SEL_LOGIC;
            end
            loong_id_pkg::OPC_OR: begin
                aluop  = loong_id_pkg::ALU_OR;
                alusel = loong_id_pkg::SEL_LOGIC;
            end
            loong_id_pkg::OPC_XOR: begin
                aluop  = loong_id_pkg::ALU_XOR;
                alusel = loong_id_pkg::SEL_LOGIC;
            end
            default: hit = 1'b0;
        endcase
    end

    assign dec.inst_valid     = hit;
    assign dec.is_privilege   = 1'b0;
    assign dec.reg_write_en   = hit;
    assign dec.reg_write_addr = hit ? inst[4:0] : '0;   // rd
    assign dec.reg1_read_en   = hit;
    assign dec.reg1_read_addr = hit ? inst[9:5] : '0;   // rj
    assign dec.reg2_read_en   = hit;
    assign dec.reg2_read_addr = hit ? inst[14:10] : '0; // rk
    assign dec.aluop          = aluop;
    assign dec.alusel         = alusel;
    assign dec.imm            = '0;
    assign dec.csr_read_en    = 1'b0;
    assign dec.csr_write_en   = 1'b0;
    assign dec.csr_addr       = '0;

endmodule

// ==== hw/decoder/id_decoder.sv ====
`timescale 1ns/1ps

module id_decoder (
    input  loong_id_pkg::word_t     inst,
    input  loong_id_pkg::plv_t      plv,
    decode_if.producer              rec,
    output logic                    exc_valid,
    output loong_id_pkg::exc_code_t exc_code
);
    decode_if d14 ();
    decode_if d3r ();
    decode_if d12 ();

    logic ine;
    logic ipe;

    id_2ri14 u_2ri14 (.inst(inst), .dec(d14));
    id_3r    u_3r    (.inst(inst), .dec(d3r));
    id_2ri12 u_2ri12 (.inst(inst), .dec(d12));

    // unclaiming decoders drive all zeros, so or-ing selects the claimer
    assign rec.inst_valid     = d14.inst_valid | d3r.inst_valid | d12.inst_valid;
    assign rec.is_privilege   = d14.is_privilege | d3r.is_privilege | d12.is_privilege;
    assign rec.reg_write_addr = d14.reg_write_addr | d3r.reg_write_addr | d12.reg_write_addr;
    assign rec.reg1_read_en   = d14.reg1_read_en | d3r.reg1_read_en | d12.reg1_read_en;
    assign rec.reg1_read_addr = d14.reg1_read_addr | d3r.reg1_read_addr | d12.reg1_read_addr;
    assign rec.reg2_read_en   = d14.reg2_read_en | d3r.reg2_read_en | d12.reg2_read_en;
    assign rec.reg2_read_addr = d14.reg2_read_addr | d3r.reg2_read_addr | d12.reg2_read_addr;
    assign rec.aluop          = d14.aluop | d3r.aluop | d12.aluop;
    assign rec.alusel         = d14.alusel | d3r.alusel | d12.alusel;
    assign rec.imm            = d14.imm | d3r.imm | d12.imm;
    assign rec.csr_read_en    = d14.csr_read_en | d3r.csr_read_en | d12.csr_read_en;
    assign rec.csr_addr       = d14.csr_addr | d3r.csr_addr | d12.csr_addr;

    assign ine = !rec.inst_valid;
    assign ipe = rec.is_privilege && (plv != 2'd0); // csr ops need plv0

    // no architectural writes under an exception
    assign rec.reg_write_en = (d14.reg_write_en | d3r.reg_write_en | d12.reg_write_en)
                              && !exc_valid;
    assign rec.csr_write_en = (d14.csr_write_en | d3r.csr_write_en | d12.csr_write_en)
                              && !exc_valid;

    assign exc_valid = ine | ipe;
    assign exc_code  = ine ? loong_id_pkg::EXC_INE :
                       ipe ? loong_id_pkg::EXC_IPE : loong_id_pkg::EXC_NONE;

    always_comb begin
        assert final ($countones({d14.inst_valid, d3r.inst_valid, d12.inst_valid}) <= 1)
            else $error("more than one format decoder claims 0x%08h", inst);
    end

endmodule

// ==== hw/id_stage.sv ====
`timescale 1ns/1ps

module id_stage (
    input  logic                    clk,
    input  logic                    arst_n,
    input  logic                    in_req,
    output logic                    in_ack,
    input  loong_id_pkg::word_t     in_pc,
    input  loong_id_pkg::word_t     in_inst,
    input  loong_id_pkg::plv_t      plv,
    output logic                    out_req,
    input  logic                    out_ack,
    output loong_id_pkg::word_t     out_pc,
    output loong_id_pkg::word_t     out_inst,
    output logic                    out_exc_valid,
    output loong_id_pkg::exc_code_t out_exc_code,
    output logic                    out_reg_write_en,
    output loong_id_pkg::reg_addr_t out_reg_write_addr,
    output logic                    out_reg1_read_en,
    output loong_id_pkg::reg_addr_t out_reg1_read_addr,
    output logic                    out_reg2_read_en,
    output loong_id_pkg::reg_addr_t out_reg2_read_addr,
    output loong_id_pkg::aluop_t    out_aluop,
    output loong_id_pkg::alusel_t   out_alusel,
    output loong_id_pkg::word_t     out_imm,
    output logic                    out_csr_read_en,
    output logic                    out_csr_write_en,
    output loong_id_pkg::csr_addr_t out_csr_addr
);
    loong_id_pkg::id_state_e state;
    loong_id_pkg::word_t     pc_q;
    loong_id_pkg::word_t     inst_q;
    loong_id_pkg::plv_t      plv_q;
    logic                    dec_exc_valid;
    loong_id_pkg::exc_code_t dec_exc_code;
    logic                    capture;
    logic                    launch;

    decode_if rec ();

    id_decoder u_dec (
        .inst(inst_q), .plv(plv_q), .rec(rec),
        .exc_valid(dec_exc_valid), .exc_code(dec_exc_code)
    );

    assign capture  = (state == loong_id_pkg::ST_IDLE) && in_req;
    assign launch   = (state == loong_id_pkg::ST_IN_ACK) && !in_req; // sender let go
    assign out_pc   = pc_q;   // held until the next capture
    assign out_inst = inst_q;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state   <= loong_id_pkg::ST_IDLE;
            in_ack  <= 1'b0;
            out_req <= 1'b0;
        end else begin
            case (state)
                loong_id_pkg::ST_IDLE: if (in_req) begin
                    in_ack <= 1'b1;
                    state  <= loong_id_pkg::ST_IN_ACK;
                end
                loong_id_pkg::ST_IN_ACK: if (!in_req) begin
                    in_ack  <= 1'b0;
                    out_req <= 1'b1;
                    state   <= loong_id_pkg::ST_OUT_REQ;
                end
                loong_id_pkg::ST_OUT_REQ: if (out_ack) begin
                    out_req <= 1'b0;
                    state   <= loong_id_pkg::ST_OUT_DONE;
                end
                default: if (!out_ack) state <= loong_id_pkg::ST_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (capture) begin
            pc_q   <= in_pc;
            inst_q <= in_inst;
            plv_q  <= plv;
        end
        if (launch) begin
            out_exc_valid      <= dec_exc_valid;
            out_exc_code       <= dec_exc_code;
            out_reg_write_en   <= rec.reg_write_en;
            out_reg_write_addr <= rec.reg_write_addr;
            out_reg1_read_en   <= rec.reg1_read_en;
            out_reg1_read_addr <= rec.reg1_read_addr;
            out_reg2_read_en   <= rec.reg2_read_en;
            out_reg2_read_addr <= rec.reg2_read_addr;
            out_aluop          <= rec.aluop;
            out_alusel         <= rec.alusel;
            out_imm            <= rec.imm;
            out_csr_read_en    <= rec.csr_read_en;
            out_csr_write_en   <= rec.csr_write_en;
            out_csr_addr       <= rec.csr_addr;
        end
    end

    a_no_overlap: assert property (@(posedge clk) disable iff (!arst_n)
        !(in_ack && out_req));

    a_out_stable: assert property (@(posedge clk) disable iff (!arst_n)
        (state inside {loong_id_pkg::ST_OUT_REQ, loong_id_pkg::ST_OUT_DONE}) |=>
        $stable({out_pc, out_inst, out_exc_valid, out_exc_code, out_reg_write_en,
                 out_reg_write_addr, out_reg1_read_en, out_reg1_read_addr,
                 out_reg2_read_en, out_reg2_read_addr, out_aluop, out_alusel,
                 out_imm, out_csr_read_en, out_csr_write_en, out_csr_addr}));

endmodule

// ==== loong_id.f ====
common/loong_id_pkg.sv
common/decode_if.sv
hw/decoder/id_2ri14.sv
hw/decoder/id_3r.sv
hw/decoder/id_2ri12.sv
hw/decoder/id_decoder.sv
hw/id_stage.sv
bench/id_checker.sv
bench/tb_id_stage.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
set -o pipefail
cd "$(dirname "$0")" || exit 1

rm -rf obj_dir sim.log
verilator --binary --timing --assert --timescale 1ns/1ps \
    --top-module tb_id_stage -f loong_id.f -o tb_id_stage \
    && ./obj_dir/tb_id_stage 2>&1 | tee sim.log \
    || { echo "build or simulation run failed"; exit 1; }

grep -q ">>> FAIL" sim.log \
    && { echo "simulation failed, see sim.log"; exit 1; } \
    || { echo "simulation passed"; exit 0; }
